/* test/gmac_rx_tests.txt */
# preamble_len payload_hex corrupt_fcs check_crc stall_after_beat
# preamble_len 0 is a dv burst without sfd, stall_after_beat - means no stall
7 00112233445566778899aabbccddeeff 0 1 -
7 ffeeddccbbaa99887766554433221100 1 1 -
7 ffeeddccbbaa99887766554433221100 1 0 -
7 0123456789abcdef0123456789abcdef0123 0 1 5
7 5a5a5a5a5a5a5a5a5a5a5a5a 0 1 -
7 0001020304050607080910111213 0 1 0
7 a0a1a2a3a4a5a6a7a8a9aaabacadaeaf 0 1 -
1 d5d5d5d555555555a0a1a2a3 0 1 -
2 101112131415161718191a1b1c1d1e1f 0 1 -
3 deadbeefcafef00d0badc0de 0 1 -
4 8080808080808080000000000000 1 1 -
5 1122334455667788 0 0 -
6 fedcba9876543210fedcba98 0 1 -
0 5566778899aabbcc 0 1 -
7 c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3 0 1 12
7 0f1e2d3c4b5a69788796a5b4c3d2e1f0 0 1 -
0 0102030405060708090a0b0c 0 1 -
7 ffffffffffffffffffffffffffffffff 0 1 -
7 00000000000000000000000000000000 1 1 -
7 2468ace013579bdf2468ace013579bdf 1 0 3
7 7766554433221100 0 1 -

/* gmac_rx.f */
hdl/gmac_rx_pkg.sv
hdl/mac_crc32.sv
hdl/gmii_rx_parser.sv
hdl/pkt_status_tracker.sv
hdl/sd_output.sv
hdl/gmac_rx_top.sv
test/gmac_rx_properties.sv
test/gmac_rx_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the gmac_rx testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f gmac_rx.f --top-module gmac_rx_tb -o gmac_rx_sim

out=$(./obj_dir/gmac_rx_sim || true)
echo "$out"

if grep -q "TEST OK" <<< "$out"; then
  exit 0
else
  exit 1
fi

/* test/gmac_rx_tb.sv */
// testbench for gmac_rx_top: data file reader, frame driver, reference model, checks
`timescale 1ns/1ps

module gmac_rx_tb
  import gmac_rx_pkg::*;
();

  logic       clk;
  logic       reset;
  logic       gmii_rx_dv;
  logic [7:0] gmii_rxd;
  logic       check_crc;
  logic       rx_srdy;
  logic       rx_drdy;
  rx_beat_t   rx_beat;
  logic       st_srdy;
  logic       st_drdy;
  rx_status_t st_status;

  // frames as read from the data file
  int         f_pre[$];
  int         f_len[$];
  int         f_base[$];
  int         f_stall[$];
  bit         f_corrupt[$];
  bit         f_check[$];
  logic [7:0] f_bytes[$];
  string      toks[$];

  // reference model output
  rx_beat_t   exp_beats[$];
  bit         exp_stall[$]; // drop rx_drdy after this beat
  rx_status_t exp_status[$];

  int cycles = 0;
  int cycle_limit = 0;
  int beat_count = 0;

  gmac_rx_top gmac_rx_top_i
  (
    .clk        (clk),
    .reset      (reset),
    .gmii_rx_dv (gmii_rx_dv),
    .gmii_rxd   (gmii_rxd),
    .check_crc  (check_crc),
    .rx_srdy    (rx_srdy),
    .rx_drdy    (rx_drdy),
    .rx_beat    (rx_beat),
    .st_srdy    (st_srdy),
    .st_drdy    (st_drdy),
    .st_status  (st_status)
  );

  always #10 clk = ~clk;

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_beat(input rx_beat_t want);
    if (rx_beat !== want)
      stop_with_failure($sformatf("[FAIL] %0t: beat %0d is code %0d data %02h, expected %0d %02h",
                                  $time, beat_count, rx_beat.code, rx_beat.data,
                                  want.code, want.data));
  endtask

  task automatic check_status(input rx_status_t want);
    if (st_status !== want)
      stop_with_failure($sformatf("[FAIL] %0t: status len %0d ok %0b trunc %0b, expected %0d %0b %0b",
                                  $time, st_status.len, st_status.crc_ok, st_status.truncated,
                                  want.len, want.crc_ok, want.truncated));
  endtask

  // whitespace separated tokens of one line into toks
  task automatic split_line(input string s);
    logic [7:0] c;
    int         start;
    bit         ws;
    toks.delete();
    start = -1;
    for (int i = 0; i < s.len(); i++)
    begin
      c  = s.getc(i);
      ws = (c == 8'h20) || (c == 8'h09) || (c == 8'h0a) || (c == 8'h0d);
      if (!ws && start < 0)
        start = i;
      else if (ws && start >= 0)
      begin
        toks.push_back(s.substr(start, i - 1));
        start = -1;
      end
    end
    if (start >= 0)
      toks.push_back(s.substr(start, s.len() - 1));
  endtask

  task automatic read_tests();
    int    fd;
    int    n;
    string line;
    string pair;
    fd = $fopen("test/gmac_rx_tests.txt", "r");
    if (fd == 0)
      stop_with_failure("could not open the test data file test/gmac_rx_tests.txt");
    while ($fgets(line, fd) != 0)
    begin
      split_line(line);
      if (toks.size() >= 5 && toks[0].getc(0) != 8'h23) // '#' starts a comment
      begin
        n = toks[1].len() / 2;
        f_pre.push_back(toks[0].atoi());
        f_len.push_back(n);
        f_base.push_back(f_bytes.size());
        for (int j = 0; j < n; j++)
        begin
          pair = toks[1].substr(2 * j, 2 * j + 1);
          f_bytes.push_back(8'(pair.atohex()));
        end
        f_corrupt.push_back(toks[2].atoi() != 0);
        f_check.push_back(toks[3].atoi() != 0);
        if (toks[4].getc(0) == 8'h2d)
          f_stall.push_back(-1);
        else
          f_stall.push_back(toks[4].atoi());
        cycle_limit = cycle_limit + 20 * (n + 16);
      end
    end
    $fclose(fd);
    cycle_limit = cycle_limit + 200;
  endtask

  // ethernet fcs, lsb-first crc-32 with final inversion
  function automatic logic [31:0] fcs_of(input int base, input int len);
    logic [31:0] r;
    r = 32'hFFFF_FFFF;
    for (int i = 0; i < len; i++)
    begin
      r = r ^ {24'h0, f_bytes[base + i]};
      for (int b = 0; b < 8; b++)
        r = r[0] ? ((r >> 1) ^ 32'hEDB8_8320) : (r >> 1);
    end
    return ~r;
  endfunction

  task automatic send_byte(input logic [7:0] b);
    gmii_rx_dv = 1'b1;
    gmii_rxd   = b;
    @(posedge clk);
    #2;
  endtask

  task automatic run_frame(input int idx);
    logic [7:0]  wire_q[$];
    logic [31:0] fcs;
    rx_beat_t    b;
    rx_status_t  s;
    int          n;
    int          k;
    int          gap;
    bit          bad_fcs;
    n       = f_len[idx];
    k       = f_stall[idx];
    bad_fcs = f_corrupt[idx] && f_check[idx];
    for (int j = 0; j < n; j++)
      wire_q.push_back(f_bytes[f_base[idx] + j]);
    fcs = fcs_of(f_base[idx], n);
    for (int j = 0; j < 4; j++)
      wire_q.push_back(fcs[8*j +: 8]); // lsb first on the wire
    if (f_corrupt[idx])
      wire_q[n + 3] = wire_q[n + 3] ^ 8'h01;

    if (f_pre[idx] > 0) // preamble length 0 is a burst without sfd, nothing expected
    begin
      if (k < 0)
      begin
        for (int j = 0; j < n + 4; j++)
        begin
          b.data = wire_q[j];
          if (j == 0)
            b.code = pcc_sop;
          else if (j == n + 3)
            b.code = bad_fcs ? pcc_badeop : pcc_eop;
          else
            b.code = pcc_data;
          exp_beats.push_back(b);
          exp_stall.push_back(1'b0);
        end
        s.len       = len_w'(n + 4);
        s.crc_ok    = !bad_fcs;
        s.truncated = 1'b0;
      end
      else
      begin
        for (int j = 0; j <= k + 1; j++)
        begin
          b.data = wire_q[j];
          b.code = (j == 0) ? pcc_sop : pcc_data;
          exp_beats.push_back(b);
          exp_stall.push_back(j == k);
        end
        b.code = pcc_badeop; // stall marker
        b.data = 8'h00;
        exp_beats.push_back(b);
        exp_stall.push_back(1'b0);
        s.len       = len_w'(k + 3);
        s.crc_ok    = 1'b0;
        s.truncated = 1'b1;
      end
      exp_status.push_back(s);
    end

    check_crc = f_check[idx];
    for (int j = 0; j < ((f_pre[idx] > 0) ? f_pre[idx] : 7); j++)
      send_byte(gmii_preamble);
    if (f_pre[idx] > 0)
    begin
      send_byte(gmii_sfd);
      foreach (wire_q[j])
        send_byte(wire_q[j]);
    end
    else
    begin
      for (int j = 0; j < n; j++)
        send_byte(wire_q[j]);
    end
    gmii_rx_dv = 1'b0;
    gmii_rxd   = 8'h00;
    gap = 12 + int'($urandom % 8);
    repeat (gap) @(posedge clk);
    #2;
  endtask

  initial
  begin : main
    clk        = 1'b0;
    reset      = 1'b1;
    gmii_rx_dv = 1'b0;
    gmii_rxd   = 8'h00;
    check_crc  = 1'b1;
    rx_drdy    = 1'b1;
    st_drdy    = 1'b1;
    void'($urandom(32'h5153_9b8f));
    read_tests();
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
    for (int i = 0; i < f_len.size(); i++)
      run_frame(i);
    while (exp_beats.size() != 0 || exp_status.size() != 0)
      @(posedge clk);
    repeat (40) @(posedge clk); // anything late shows up as unexpected
    $display("TEST OK");
    $finish;
  end

  // sampled mid-cycle, a transfer happens at the next rising edge
  initial
  begin : beat_monitor
    rx_beat_t want;
    bit       stall;
    forever
    begin
      @(negedge clk);
      if (rx_srdy === 1'b1 && rx_drdy === 1'b1)
      begin
        if (exp_beats.size() == 0)
          stop_with_failure($sformatf("a beat came out at %0t when none was expected", $time));
        want  = exp_beats.pop_front();
        stall = exp_stall.pop_front();
        check_beat(want);
        beat_count++;
        if (stall)
        begin
          @(posedge clk);
          #2;
          rx_drdy = 1'b0;
          repeat (6) @(posedge clk);
          #2;
          rx_drdy = 1'b1;
        end
      end
    end
  end

  always @(negedge clk)
  begin : status_monitor
    rx_status_t want;
    if (st_srdy === 1'b1 && st_drdy === 1'b1)
    begin
      if (exp_status.size() == 0)
        stop_with_failure($sformatf("a status record came out at %0t with none expected", $time));
      want = exp_status.pop_front();
      check_status(want);
    end
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit)
      stop_with_failure($sformatf("timeout after %0d cycles, frames still pending", cycles));
  end

endmodule

/* test/gmac_rx_properties.sv */
// handshake and framing assertions for the gmac_rx_top output ports
`timescale 1ns/1ps

module gmac_rx_properties
  import gmac_rx_pkg::*;
(
  input logic     clk,
  input logic     reset,
  input logic     rx_srdy,
  input logic     rx_drdy,
  input rx_beat_t rx_beat,
  input logic     st_srdy
);

  logic frame_open; // inside a frame since its sop

  always_ff @(posedge clk)
  begin
    if (reset)
      frame_open <= 1'b0;
    else if (rx_srdy && rx_drdy)
    begin
      if (rx_beat.code == pcc_sop)
        frame_open <= 1'b1;
      else if (rx_beat.code == pcc_eop || rx_beat.code == pcc_badeop)
        frame_open <= 1'b0;
    end
  end

  beat_held: assert property (@(posedge clk) disable iff (reset)
    (rx_srdy && !rx_drdy) |=> (rx_srdy && $stable(rx_beat)))
    else $error("rx_beat changed while waiting for rx_drdy");

  idle_after_reset: assert property (@(posedge clk) reset |=> (!rx_srdy && !st_srdy))
    else $error("output valid right after reset");

  one_sop: assert property (@(posedge clk) disable iff (reset)
    (rx_srdy && rx_drdy && rx_beat.code == pcc_sop) |-> !frame_open)
    else $error("second sop without an end of frame");

endmodule

bind gmac_rx_top gmac_rx_properties props_i
(
  .clk     (clk),
  .reset   (reset),
  .rx_srdy (rx_srdy),
  .rx_drdy (rx_drdy),
  .rx_beat (rx_beat),
  .st_srdy (st_srdy)
);

/* hdl/gmac_rx_top.sv */
// gigabit mac receive top, parser, crc engine, status tracker and output stages
`timescale 1ns/1ps

module gmac_rx_top
  import gmac_rx_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       gmii_rx_dv,
  input  logic [7:0] gmii_rxd,
  input  logic       check_crc,
  output logic       rx_srdy,
  input  logic       rx_drdy,
  output rx_beat_t   rx_beat,
  output logic       st_srdy,
  input  logic       st_drdy,
  output rx_status_t st_status
);

  logic        crc_clear;
  logic        crc_valid;
  logic [7:0]  crc_data;
  logic [31:0] crc;
  logic        ic_srdy;
  logic        ic_drdy;
  rx_beat_t    ic_data;
  logic        beat_taken;
  logic        frame_end;
  logic        truncated;
  logic        st_in_srdy;
  logic        st_in_drdy;
  rx_status_t  st_in_data;

  gmii_rx_parser parser_i
  (
    .clk        (clk),
    .reset      (reset),
    .gmii_rx_dv (gmii_rx_dv),
    .gmii_rxd   (gmii_rxd),
    .check_crc  (check_crc),
    .crc        (crc),
    .ic_drdy    (ic_drdy),
    .crc_clear  (crc_clear),
    .crc_valid  (crc_valid),
    .crc_data   (crc_data),
    .ic_srdy    (ic_srdy),
    .ic_data    (ic_data),
    .beat_taken (beat_taken),
    .frame_end  (frame_end),
    .truncated  (truncated)
  );

  mac_crc32 crc_i
  (
    .clk   (clk),
    .clear (crc_clear),
    .valid (crc_valid),
    .data  (crc_data),
    .crc   (crc)
  );

  pkt_status_tracker tracker_i
  (
    .clk        (clk),
    .reset      (reset),
    .beat_taken (beat_taken),
    .beat_code  (ic_data.code), // code of the beat being handed over
    .frame_end  (frame_end),
    .truncated  (truncated),
    .st_in_drdy (st_in_drdy),
    .st_in_srdy (st_in_srdy),
    .st_in_data (st_in_data)
  );

  // frame beats
  sd_output #(.payload_t(rx_beat_t)) beat_out_i
  (
    .clk     (clk),
    .reset   (reset),
    .ic_srdy (ic_srdy),
    .ic_drdy (ic_drdy),
    .ic_data (ic_data),
    .p_srdy  (rx_srdy),
    .p_drdy  (rx_drdy),
    .p_data  (rx_beat)
  );

  // one status record per frame
  sd_output #(.payload_t(rx_status_t)) status_out_i
  (
    .clk     (clk),
    .reset   (reset),
    .ic_srdy (st_in_srdy),
    .ic_drdy (st_in_drdy),
    .ic_data (st_in_data),
    .p_srdy  (st_srdy),
    .p_drdy  (st_drdy),
    .p_data  (st_status)
  );

endmodule

/* hdl/sd_output.sv */
// one-entry srdy/drdy holding register for any payload type
`timescale 1ns/1ps

module sd_output
  import gmac_rx_pkg::*;
#(
  parameter type payload_t = rx_beat_t
)
(
  input  logic     clk,
  input  logic     reset,
  input  logic     ic_srdy,
  output logic     ic_drdy,
  input  payload_t ic_data,
  output logic     p_srdy,
  input  logic     p_drdy,
  output payload_t p_data
);

  logic     full;
  payload_t hold;

  // room when empty or when the held item leaves this cycle
  assign ic_drdy = !full | p_drdy;

  always_ff @(posedge clk)
  begin
    if (reset)
      full <= 1'b0;
    else if (ic_srdy & ic_drdy)
      full <= 1'b1;
    else if (p_drdy)
      full <= 1'b0;
    if (ic_srdy & ic_drdy)
      hold <= ic_data;
  end

  assign p_srdy = full;
  assign p_data = hold;

endmodule

/* hdl/pkt_status_tracker.sv */
// per-frame beat counter and status record builder
`timescale 1ns/1ps

module pkt_status_tracker
  import gmac_rx_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       beat_taken,
  input  pcc_t       beat_code,
  input  logic       frame_end,
  input  logic       truncated,
  input  logic       st_in_drdy,
  output logic       st_in_srdy,
  output rx_status_t st_in_data
);

  logic [len_w-1:0] count;
  logic [len_w-1:0] len_inc;
  logic             st_full;
  rx_status_t       st_rec;

  // saturating increment
  assign len_inc = (count == {len_w{1'b1}}) ? count : count + len_w'(1);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      count   <= '0;
      st_full <= 1'b0;
    end
    else
    begin
      if (beat_taken)
      begin
        if (beat_code == pcc_sop)
          count <= len_w'(1); // new frame
        else
          count <= len_inc;
      end
      if (frame_end)
        st_full <= 1'b1;
      else if (st_in_drdy)
        st_full <= 1'b0;
    end
    // frame_end comes with the final beat, so that beat is counted here
    if (frame_end)
    begin
      st_rec.len       <= len_inc;
      st_rec.crc_ok    <= (beat_code == pcc_eop);
      st_rec.truncated <= truncated;
    end
  end

  assign st_in_srdy = st_full;
  assign st_in_data = st_rec;

endmodule

/* hdl/gmii_rx_parser.sv */
// gmii input registers, frame parser fsm and fcs comparison
`timescale 1ns/1ps

module gmii_rx_parser
  import gmac_rx_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        gmii_rx_dv,
  input  logic [7:0]  gmii_rxd,
  input  logic        check_crc,
  input  logic [31:0] crc,
  input  logic        ic_drdy,
  output logic        crc_clear,
  output logic        crc_valid,
  output logic [7:0]  crc_data,
  output logic        ic_srdy,
  output rx_beat_t    ic_data,
  output logic        beat_taken,
  output logic        frame_end,
  output logic        truncated
);

  typedef enum logic [6:0]
  {
    st_idle      = 7'b0000001,
    st_preamble  = 7'b0000010,
    st_sop       = 7'b0000100,
    st_payload   = 7'b0001000,
    st_fcs_check = 7'b0010000,
    st_trunc     = 7'b0100000,
    st_sink      = 7'b1000000
  } state_t;

  state_t      state_q, state_d;
  logic        rxdv1, rxdv2;
  logic [7:0]  rxd1, rxd2;
  logic [31:0] fcs_sr;  // last four bytes, oldest in [7:0]
  logic [3:0]  sr_fill; // fills from the top, [0] set once fcs_sr is full
  logic        shift;
  logic        beat_load;
  rx_beat_t    beat_d;
  logic        ic_srdy_q;
  rx_beat_t    ic_data_q;

  // two input stages
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rxdv1 <= 1'b0;
      rxdv2 <= 1'b0;
    end
    else
    begin
      rxdv1 <= gmii_rx_dv;
      rxdv2 <= rxdv1;
    end
    rxd1 <= gmii_rxd;
    rxd2 <= rxd1;
  end

  always_comb
  begin
    state_d     = state_q;
    beat_load   = 1'b0;
    beat_d.code = pcc_data;
    beat_d.data = rxd2;
    shift       = 1'b0;
    crc_clear   = 1'b0;

    case (state_q)
      st_idle:
      begin
        crc_clear = 1'b1;
        if (rxdv2)
        begin
          if (rxd2 == gmii_sfd)
            state_d = st_sop; // no preamble at all
          else if (rxd2 == gmii_preamble)
            state_d = st_preamble;
          else
            state_d = st_sink;
        end
      end

      st_preamble:
      begin
        crc_clear = 1'b1;
        if (!rxdv2)
          state_d = st_idle;
        else if (rxd2 == gmii_sfd)
          state_d = st_sop;
        else if (rxd2 != gmii_preamble)
          state_d = st_sink;
      end

      st_sop:
      begin
        if (!rxdv2)
          state_d = st_idle;
        else if (!ic_drdy)
          state_d = st_sink; // drop whole frame, nothing sent yet
        else
        begin
          beat_load   = 1'b1;
          beat_d.code = pcc_sop;
          shift       = 1'b1;
          state_d     = st_payload;
        end
      end

      st_payload:
      begin
        if (!ic_drdy)
        begin
          // pending beat replaced by the error marker
          beat_load   = 1'b1;
          beat_d.code = pcc_badeop;
          beat_d.data = 8'h00;
          state_d     = st_trunc;
        end
        else if (!rxdv1)
        begin
          shift   = 1'b1; // last byte, sent after the compare
          state_d = st_fcs_check;
        end
        else
        begin
          beat_load = 1'b1;
          shift     = 1'b1;
        end
      end

      st_fcs_check:
      begin
        beat_load   = 1'b1;
        beat_d.data = fcs_sr[31:24];
        if (check_crc && (fcs_sr != crc))
          beat_d.code = pcc_badeop;
        else
          beat_d.code = pcc_eop;
        state_d = st_idle;
      end

      st_trunc:
      begin
        if (ic_drdy)
          state_d = st_sink;
      end

      st_sink:
      begin
        if (!rxdv2)
          state_d = st_idle;
      end

      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state_q   <= st_idle;
      ic_srdy_q <= 1'b0;
      sr_fill   <= 4'b0000;
    end
    else
    begin
      state_q <= state_d;
      if (beat_load)
        ic_srdy_q <= 1'b1;
      else if (ic_drdy)
        ic_srdy_q <= 1'b0;
      if (crc_clear)
        sr_fill <= 4'b0000;
      else if (shift)
        sr_fill <= {1'b1, sr_fill[3:1]};
    end
    if (beat_load)
      ic_data_q <= beat_d;
    if (shift)
      fcs_sr <= {rxd2, fcs_sr[31:8]};
  end

  // byte leaving the fcs window goes into the crc
  assign crc_valid = shift & sr_fill[0];
  assign crc_data  = fcs_sr[7:0];

  assign ic_srdy    = ic_srdy_q;
  assign ic_data    = ic_data_q;
  assign beat_taken = ic_srdy_q & ic_drdy;
  assign frame_end  = beat_taken &
                      ((ic_data_q.code == pcc_eop) || (ic_data_q.code == pcc_badeop));
  assign truncated  = (state_q == st_trunc); // badeop from a stall leaves only here

endmodule

/* hdl/mac_crc32.sv */
// byte-serial reflected ethernet crc-32 engine
`timescale 1ns/1ps

module mac_crc32
  import gmac_rx_pkg::*;
(
  input  logic        clk,
  input  logic        clear,
  input  logic        valid,
  input  logic [7:0]  data,
  output logic [31:0] crc
);

  logic [31:0] crc_q;

  // one byte through the lsb-first crc, eight shifts
  function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
    logic [31:0] poly_rev;
    logic [31:0] r;
    for (int i = 0; i < 32; i++)
    begin
      poly_rev[i] = crc_poly[31-i]; // reflected polynomial
    end
    r = c ^ {24'h0, d};
    for (int b = 0; b < 8; b++)
    begin
      if (r[0])
        r = (r >> 1) ^ poly_rev;
      else
        r = r >> 1;
    end
    return r;
  endfunction

  always_ff @(posedge clk)
  begin
    if (clear)
      crc_q <= crc_init;
    else if (valid)
      crc_q <= crc_byte(crc_q, data);
  end

  // final complement as sent on the wire
  assign crc = ~crc_q;

endmodule

/* hdl/gmac_rx_pkg.sv */
// packet control codes, gmii and crc constants, beat and status record types
package gmac_rx_pkg;

  // width of the per-frame byte counter
  localparam int len_w = 14;

  // gmii framing bytes
  localparam logic [7:0] gmii_preamble = 8'h55;
  localparam logic [7:0] gmii_sfd      = 8'hD5;

  // ethernet crc-32, normal (msb first) form of the polynomial
  localparam logic [31:0] crc_poly = 32'h04C11DB7;
  localparam logic [31:0] crc_init = 32'hFFFFFFFF;

  // packet control code carried with every beat
  typedef enum logic [1:0]
  {
    pcc_data   = 2'b00,
    pcc_sop    = 2'b01,
    pcc_eop    = 2'b10,
    pcc_badeop = 2'b11 // frame ended with an error
  } pcc_t;

  // one byte of frame data on the beat port
  typedef struct packed
  {
    pcc_t       code;
    logic [7:0] data;
  } rx_beat_t;

  // one record per received frame on the status port
  typedef struct packed
  {
    logic [len_w-1:0] len;       // bytes passed out, fcs included
    logic             crc_ok;
    logic             truncated; // cut short by output stall
  } rx_status_t;

endpackage
